//--- fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Data path and byte address width.
`define FETCH_XLEN 32

// Instruction memory depth in 32-bit words.
// A word index at or above this aborts the fetch.
`define FETCH_MEM_WORDS 256

// Branch history table size.
// Indexed by PC bits [2 +: log2(entries)].
`define FETCH_BHT_ENTRIES 64

// Fetch address after reset.
`define FETCH_RESET_PC 32'h0000_0000

`endif

//--- fetch_pkg.sv
`default_nettype none
`include "fetch_defs.svh"

package fetch_pkg;

        // Instruction or data word.
        typedef logic [`FETCH_XLEN-1:0] word_t;

        // Byte address.
        typedef logic [`FETCH_XLEN-1:0] addr_t;

        // History table index, sized from the entry count.
        typedef logic [$clog2(`FETCH_BHT_ENTRIES)-1:0] bht_idx_t;

        // Two-bit counter. 0 SNT, 1 WNT, 2 WT, 3 ST.
        typedef logic [1:0] pred_t;

        // Resolved fetch control. All zero means hold.
        typedef struct packed {
                logic advance;          // Capture new fetch, step PC.
                logic flush;            // Invalidate, load redirect PC.
                logic sleep;            // Capture invalid, hold PC.
        } fetch_ctrl_t;

        // Decode-facing bundle.
        typedef struct packed {
                word_t instruction;     // Fetched word, 0 on abort.
                logic  valid;           // Instruction valid.
                logic  abort;           // Instruction abort.
                addr_t pc;              // PC of this word.
                addr_t pc_plus;         // PC + 8, or + 4 in Thumb.
        } fetch_bundle_t;

        // Abort sleep machine.
        typedef enum logic {
                AWAKE,
                ASLEEP
        } sleep_state_t;

endpackage

`default_nettype wire

//--- fetch_ctrl.sv
`default_nettype none

module fetch_ctrl
(
        input  wire                   i_clk,
        input  wire                   i_reset,

        // Clear and stall requests, highest priority first.
        input  wire                   i_clear_from_writeback,
        input  wire                   i_data_stall,
        input  wire                   i_clear_from_alu,
        input  wire                   i_stall_from_shifter,
        input  wire                   i_stall_from_issue,
        input  wire                   i_stall_from_decode,
        input  wire                   i_clear_from_decode,

        input  wire                   i_abort_ff,       // Registered abort from buffer.
        output fetch_pkg::fetch_ctrl_t o_ctrl
);

        fetch_pkg::sleep_state_t state_q;
        logic                    clear_win;             // A clear owns this cycle.
        logic                    stall_win;             // A stall owns this cycle.

        // Walk the priority chain. First request found wins.
        always_comb
        begin
                clear_win = 1'b0;
                stall_win = 1'b0;
                if (i_clear_from_writeback)
                        clear_win = 1'b1;
                else if (i_data_stall)
                        stall_win = 1'b1;
                else if (i_clear_from_alu)
                        clear_win = 1'b1;
                else if (i_stall_from_shifter || i_stall_from_issue || i_stall_from_decode)
                        stall_win = 1'b1;
                else if (i_clear_from_decode)
                        clear_win = 1'b1;
        end

        // Map the winner onto the control bundle.
        // The abort cycle itself already counts as asleep, so the
        // word after the abort is never captured.
        always_comb
        begin
                o_ctrl = '0;                            // Default is hold.
                if (clear_win)
                        o_ctrl.flush = 1'b1;
                else if (!stall_win)
                begin
                        if (state_q == fetch_pkg::ASLEEP || i_abort_ff)
                                o_ctrl.sleep = 1'b1;
                        else
                                o_ctrl.advance = 1'b1;
                end
        end

        // Sleep machine. Any winning clear wakes the unit.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_q <= fetch_pkg::AWAKE;
                else if (clear_win)
                        state_q <= fetch_pkg::AWAKE;
                else if (!stall_win && i_abort_ff)
                        state_q <= fetch_pkg::ASLEEP;  // Abort reached the buffer.
        end

        // At most one action per cycle.
        a_ctrl_onehot: assert property (@(posedge i_clk) $onehot0(o_ctrl));

        // Buffer abort is cleared by the same reset, so no sleep follows it.
        a_reset_awake: assert property (@(posedge i_clk)
                i_reset |=> (state_q == fetch_pkg::AWAKE) && !o_ctrl.sleep);

endmodule

`default_nettype wire

//--- pc_sequencer.sv
`default_nettype none
`include "fetch_defs.svh"

module pc_sequencer
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire fetch_pkg::fetch_ctrl_t i_ctrl,
        input  wire fetch_pkg::addr_t  i_redirect_pc,     // Target of the winning clear.
        output fetch_pkg::addr_t       o_pc,              // Current fetch address.
        output fetch_pkg::bht_idx_t    o_bht_idx          // History table read index.
);

        localparam int IDX_W = $bits(fetch_pkg::bht_idx_t);

        fetch_pkg::addr_t pc_q;
        fetch_pkg::addr_t pc_next;

        // Next PC select.
        // Flush takes the redirect, advance steps one word.
        // Sleep and hold keep the PC where it is.
        always_comb
        begin
                pc_next = pc_q;
                if (i_ctrl.flush)
                        pc_next = i_redirect_pc;
                else if (i_ctrl.advance)
                        pc_next = pc_q + fetch_pkg::addr_t'(4);  // Always word step.
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        pc_q <= fetch_pkg::addr_t'(`FETCH_RESET_PC);
                else
                        pc_q <= pc_next;
        end

        assign o_pc = pc_q;

        // Table is indexed by word, so skip the byte offset bits.
        assign o_bht_idx = pc_q[2 +: IDX_W];

        // Redirect targets from later stages must keep word alignment.
        a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
                pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- instr_mem.sv
`default_nettype none
`include "fetch_defs.svh"

module instr_mem
(
        input  wire                   i_clk,

        // Refill port.
        input  wire                   i_fill_en,
        input  wire fetch_pkg::addr_t i_fill_addr,        // Byte address.
        input  wire fetch_pkg::word_t i_fill_data,

        // Fetch read port.
        input  wire fetch_pkg::addr_t i_pc,
        output fetch_pkg::word_t      o_word,             // 0 on abort.
        output logic                  o_abort             // Index out of range.
);

        localparam int AW = $clog2(`FETCH_MEM_WORDS);

        fetch_pkg::word_t       mem [`FETCH_MEM_WORDS];
        logic [`FETCH_XLEN-3:0] rd_widx;                  // Full word index of the PC.
        logic [`FETCH_XLEN-3:0] wr_widx;
        logic                   wr_in_range;

        assign rd_widx = i_pc[`FETCH_XLEN-1:2];
        assign wr_widx = i_fill_addr[`FETCH_XLEN-1:2];
        assign wr_in_range = (wr_widx < `FETCH_MEM_WORDS);

        // Refill write. Out of range fills are dropped.
        always_ff @(posedge i_clk)
        begin
                if (i_fill_en && wr_in_range)
                        mem[wr_widx[AW-1:0]] <= i_fill_data;
        end

        // Combinational read with abort check.
        always_comb
        begin
                o_abort = (rd_widx >= `FETCH_MEM_WORDS);
                if (o_abort)
                        o_word = '0;                      // Abort payload.
                else
                        o_word = mem[rd_widx[AW-1:0]];
        end

endmodule

`default_nettype wire

//--- branch_history.sv
`default_nettype none
`include "fetch_defs.svh"

module branch_history
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire fetch_pkg::fetch_ctrl_t i_ctrl,
        input  wire fetch_pkg::bht_idx_t i_rd_idx,        // From fetch PC.

        // Update from execute.
        input  wire                    i_data_stall,
        input  wire                    i_clear_from_alu,   // Mispredict.
        input  wire                    i_confirm_from_alu, // Prediction held.
        input  wire fetch_pkg::addr_t  i_pc_from_alu,
        input  wire fetch_pkg::pred_t  i_taken,           // Counter carried with the branch.

        output fetch_pkg::pred_t       o_taken            // Aligned with fetch bundle.
);

        localparam int IDX_W = $bits(fetch_pkg::bht_idx_t);

        localparam fetch_pkg::pred_t SNT = 2'd0;          // Strongly not taken.
        localparam fetch_pkg::pred_t WNT = 2'd1;          // Weakly not taken.
        localparam fetch_pkg::pred_t WT  = 2'd2;          // Weakly taken.
        localparam fetch_pkg::pred_t ST  = 2'd3;          // Strongly taken.

        fetch_pkg::pred_t    bht_q [`FETCH_BHT_ENTRIES];
        fetch_pkg::bht_idx_t wr_idx;
        logic                wr_en;

        // Counter update. A clear nudges toward the other outcome.
        function automatic fetch_pkg::pred_t next_pred(input fetch_pkg::pred_t cur,
                                                       input logic mispredict);
                if (mispredict)
                        return (cur == SNT || cur == ST) ? ((cur == SNT) ? WNT : WT)
                                                          : ((cur == WNT) ? WT : WNT);
                else
                        return (cur[1]) ? ST : SNT;       // Confirm saturates.
        endfunction

        assign wr_en  = !i_data_stall && (i_clear_from_alu || i_confirm_from_alu);
        assign wr_idx = i_pc_from_alu[2 +: IDX_W];

        // Table write. Nonblocking, so a same-cycle read sees the old value.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < `FETCH_BHT_ENTRIES; i++)
                                bht_q[i] <= SNT;
                end
                else if (wr_en)
                        bht_q[wr_idx] <= next_pred(i_taken, i_clear_from_alu);
        end

        // Registered read, moves only with the fetch buffer.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_taken <= SNT;
                else if (i_ctrl.advance)
                        o_taken <= bht_q[i_rd_idx];
        end

endmodule

`default_nettype wire

//--- fetch_buffer.sv
`default_nettype none
`include "fetch_defs.svh"

module fetch_buffer
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire fetch_pkg::fetch_ctrl_t i_ctrl,
        input  wire                    i_thumb,           // Thumb mode, PC + 4.
        input  wire fetch_pkg::addr_t  i_pc,
        input  wire fetch_pkg::word_t  i_word,
        input  wire                    i_abort,           // From memory, same cycle.
        output fetch_pkg::fetch_bundle_t o_fetch,
        output logic                   o_abort_ff         // Back to control for sleep.
);

        fetch_pkg::fetch_bundle_t fetch_q;
        fetch_pkg::addr_t         pc_off;

        // Offset the later stages expect as the PC reading.
        assign pc_off = i_thumb ? fetch_pkg::addr_t'(4) : fetch_pkg::addr_t'(8);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        fetch_q.instruction <= '0;
                        fetch_q.valid       <= 1'b0;
                        fetch_q.abort       <= 1'b0;
                        fetch_q.pc          <= fetch_pkg::addr_t'(`FETCH_RESET_PC);
                        fetch_q.pc_plus     <= fetch_pkg::addr_t'(`FETCH_RESET_PC) +
                                               fetch_pkg::addr_t'(8);
                end
                else if (i_ctrl.flush || i_ctrl.sleep)
                begin
                        fetch_q.valid <= 1'b0;            // Bubble. Payload kept.
                        fetch_q.abort <= 1'b0;
                end
                else if (i_ctrl.advance)
                begin
                        fetch_q.instruction <= i_word;
                        fetch_q.valid       <= !i_abort;  // Abort is never valid.
                        fetch_q.abort       <= i_abort;
                        fetch_q.pc          <= i_pc;
                        fetch_q.pc_plus     <= i_pc + pc_off;
                end
        end

        assign o_fetch    = fetch_q;
        assign o_abort_ff = fetch_q.abort;

        // Decode must never see a valid aborted word.
        a_valid_abort: assert property (@(posedge i_clk) disable iff (i_reset)
                !(fetch_q.valid && fetch_q.abort));

endmodule

`default_nettype wire

//--- fetch_top.sv
`default_nettype none

module fetch_top
(
        input  wire                   i_clk,
        input  wire                   i_reset,

        // Clear and stall requests, highest priority first.
        input  wire                   i_clear_from_writeback,
        input  wire                   i_data_stall,
        input  wire                   i_clear_from_alu,
        input  wire                   i_stall_from_shifter,
        input  wire                   i_stall_from_issue,
        input  wire                   i_stall_from_decode,
        input  wire                   i_clear_from_decode,

        input  wire fetch_pkg::addr_t i_redirect_pc,      // Target for the winning clear.
        input  wire                   i_thumb,

        // Refill port.
        input  wire                   i_fill_en,
        input  wire fetch_pkg::addr_t i_fill_addr,
        input  wire fetch_pkg::word_t i_fill_data,

        // Branch update.
        input  wire                   i_confirm_from_alu,
        input  wire fetch_pkg::addr_t i_pc_from_alu,
        input  wire fetch_pkg::pred_t i_taken,

        // To decode.
        output fetch_pkg::fetch_bundle_t o_fetch,
        output fetch_pkg::pred_t      o_taken
);

        fetch_pkg::fetch_ctrl_t ctrl;
        fetch_pkg::addr_t       pc;
        fetch_pkg::bht_idx_t    bht_idx;
        fetch_pkg::word_t       mem_word;
        logic                   mem_abort;
        logic                   abort_ff;

        fetch_ctrl u_ctrl (
                .i_clk, .i_reset,
                .i_clear_from_writeback, .i_data_stall, .i_clear_from_alu,
                .i_stall_from_shifter, .i_stall_from_issue, .i_stall_from_decode,
                .i_clear_from_decode,
                .i_abort_ff(abort_ff), .o_ctrl(ctrl));

        pc_sequencer u_pc (
                .i_clk, .i_reset, .i_ctrl(ctrl), .i_redirect_pc,
                .o_pc(pc), .o_bht_idx(bht_idx));

        instr_mem u_mem (
                .i_clk, .i_fill_en, .i_fill_addr, .i_fill_data,
                .i_pc(pc), .o_word(mem_word), .o_abort(mem_abort));

        branch_history u_bht (
                .i_clk, .i_reset, .i_ctrl(ctrl), .i_rd_idx(bht_idx),
                .i_data_stall, .i_clear_from_alu, .i_confirm_from_alu,
                .i_pc_from_alu, .i_taken, .o_taken);

        fetch_buffer u_buf (
                .i_clk, .i_reset, .i_ctrl(ctrl), .i_thumb, .i_pc(pc),
                .i_word(mem_word), .i_abort(mem_abort),
                .o_fetch, .o_abort_ff(abort_ff));

endmodule

`default_nettype wire

//--- tb_fetch.sv
`default_nettype none
`include "fetch_defs.svh"

module tb_fetch;

        localparam int N_TESTS   = 5;
        localparam int MEM_AW    = $clog2(`FETCH_MEM_WORDS);
        localparam int IDX_W     = $clog2(`FETCH_BHT_ENTRIES);
        // Memory refill plus the per-test budget and margin.
        localparam int WD_CYCLES = `FETCH_MEM_WORDS + 60 * N_TESTS + 200;

        logic i_clk = 1'b0;                                    // Low from the start.
        logic i_reset;
        logic i_clear_from_writeback, i_data_stall, i_clear_from_alu;
        logic i_stall_from_shifter, i_stall_from_issue, i_stall_from_decode;
        logic i_clear_from_decode, i_thumb, i_fill_en, i_confirm_from_alu;
        fetch_pkg::addr_t         i_redirect_pc, i_fill_addr, i_pc_from_alu;
        fetch_pkg::word_t         i_fill_data;
        fetch_pkg::pred_t         i_taken;
        fetch_pkg::fetch_bundle_t o_fetch;
        fetch_pkg::pred_t         o_taken;

        fetch_pkg::word_t         m_mem [`FETCH_MEM_WORDS];    // Mirror of the memory.
        fetch_pkg::pred_t         m_bht [`FETCH_BHT_ENTRIES];  // Mirror of the counters.
        fetch_pkg::addr_t         m_pc;                        // Model fetch PC.
        logic                     m_sleep;                     // Model asleep after abort.
        fetch_pkg::fetch_bundle_t exp_fetch;
        fetch_pkg::pred_t         exp_taken;
        int seed = 47;
        int errors = 0;
        int checks = 0;
        int test_base = 0;                                     // Errors before this test.

        fetch_top UUT (.*);

        initial
        begin
                forever #4 i_clk = ~i_clk;
        end

        // Expected bundle for one fetch.
        function automatic fetch_pkg::fetch_bundle_t ref_fetch(input fetch_pkg::addr_t pc,
                                                               input logic thumb);
                fetch_pkg::fetch_bundle_t b;
                b.pc          = pc;
                b.pc_plus     = pc + (thumb ? 32'd4 : 32'd8);
                b.abort       = (pc >> 2) >= `FETCH_MEM_WORDS; // Beyond the memory.
                b.valid       = !b.abort;
                b.instruction = b.abort ? '0 : m_mem[pc[2 +: MEM_AW]];
                return b;
        endfunction

        // Two-bit counter rule, mispredict or confirm.
        function automatic fetch_pkg::pred_t ref_counter(input fetch_pkg::pred_t cur,
                                                         input logic mispredict);
                fetch_pkg::pred_t nxt;
                case (cur)
                        2'd0:    nxt = mispredict ? 2'd1 : 2'd0;
                        2'd1:    nxt = mispredict ? 2'd2 : 2'd0;
                        2'd2:    nxt = mispredict ? 2'd1 : 2'd3;
                        default: nxt = mispredict ? 2'd2 : 2'd3;
                endcase
                return nxt;
        endfunction

        // Advance the model by one clock edge.
        task automatic model_step();
                logic clear_win;
                logic stall_win;
                clear_win = 1'b0;
                stall_win = 1'b0;
                if (i_clear_from_writeback)
                        clear_win = 1'b1;
                else if (i_data_stall)
                        stall_win = 1'b1;
                else if (i_clear_from_alu)
                        clear_win = 1'b1;
                else if (i_stall_from_shifter || i_stall_from_issue || i_stall_from_decode)
                        stall_win = 1'b1;
                else if (i_clear_from_decode)
                        clear_win = 1'b1;
                if (i_reset)
                begin
                        m_pc              = `FETCH_RESET_PC;
                        m_sleep           = 1'b0;
                        exp_fetch         = '0;
                        exp_fetch.pc      = `FETCH_RESET_PC;
                        exp_fetch.pc_plus = `FETCH_RESET_PC + 8;
                        exp_taken         = '0;
                        foreach (m_bht[i])
                                m_bht[i] = '0;
                end
                else
                begin
                        if (clear_win)
                        begin
                                exp_fetch.valid = 1'b0;         // One bubble.
                                exp_fetch.abort = 1'b0;
                                m_pc            = i_redirect_pc;
                                m_sleep         = 1'b0;
                        end
                        else if (!stall_win && m_sleep)
                        begin
                                exp_fetch.valid = 1'b0;         // Quiet, PC held.
                                exp_fetch.abort = 1'b0;
                        end
                        else if (!stall_win)
                        begin
                                exp_fetch = ref_fetch(m_pc, i_thumb);
                                exp_taken = m_bht[m_pc[2 +: IDX_W]];  // Old counter.
                                m_sleep   = exp_fetch.abort;
                                m_pc      = m_pc + 4;
                        end
                        if (!i_data_stall && (i_clear_from_alu || i_confirm_from_alu))
                                m_bht[i_pc_from_alu[2 +: IDX_W]] =
                                        ref_counter(i_taken, i_clear_from_alu);
                end
                if (i_fill_en && (i_fill_addr >> 2) < `FETCH_MEM_WORDS)
                        m_mem[i_fill_addr[2 +: MEM_AW]] = i_fill_data;
        endtask

        // Compare the flop outputs, then move the model past this edge.
        always @(posedge i_clk)
        begin
                if (!i_reset)
                begin
                        checks = checks + 2;
                        assert (o_fetch === exp_fetch)
                        else
                        begin
                                errors++;
                                $display("Fail o_fetch at %0t: expected %h, got %h",
                                         $time, exp_fetch, o_fetch);
                        end
                        assert (o_taken === exp_taken)
                        else
                        begin
                                errors++;
                                $display("Fail o_taken at %0t: expected %h, got %h",
                                         $time, exp_taken, o_taken);
                        end
                end
                model_step();
        end

        // No requests, no strobes.
        task automatic idle_inputs();
                i_clear_from_writeback = 1'b0;
                i_data_stall           = 1'b0;
                i_clear_from_alu       = 1'b0;
                i_stall_from_shifter   = 1'b0;
                i_stall_from_issue     = 1'b0;
                i_stall_from_decode    = 1'b0;
                i_clear_from_decode    = 1'b0;
                i_confirm_from_alu     = 1'b0;
                i_fill_en              = 1'b0;
        endtask

        // One-cycle clear. Source 0 writeback, 1 ALU, else decode.
        task automatic clear_to(input int src, input fetch_pkg::addr_t target);
                i_redirect_pc = target;
                i_pc_from_alu = target;                         // ALU clear also trains.
                i_taken       = m_bht[target[2 +: IDX_W]];
                case (src)
                        0:       i_clear_from_writeback = 1'b1;
                        1:       i_clear_from_alu       = 1'b1;
                        default: i_clear_from_decode    = 1'b1;
                endcase
                @(negedge i_clk);
                idle_inputs();
        endtask

        // Resolved branch from execute.
        task automatic bht_update(input fetch_pkg::addr_t pc, input logic mispredict);
                i_pc_from_alu = pc;
                i_taken       = m_bht[pc[2 +: IDX_W]];          // Counter carried along.
                i_redirect_pc = 32'h300;
                if (mispredict)
                        i_clear_from_alu = 1'b1;
                else
                        i_confirm_from_alu = 1'b1;
                @(negedge i_clk);
                idle_inputs();
        endtask

        // Wait for fetching to resume, bounded.
        task automatic wait_valid(input int limit);
                int n;
                n = 0;
                while (!o_fetch.valid && n < limit)
                begin
                        @(negedge i_clk);
                        n++;
                end
                assert (o_fetch.valid)
                else
                begin
                        errors++;
                        $display("No valid fetch within %0d cycles after a redirect", limit);
                end
        endtask

        task automatic end_test(input string name);
                $display("Test %s done: %0d errors", name, errors - test_base);
                test_base = errors;
        endtask

        initial
        begin
                idle_inputs();
                i_reset = 1'b1;
                i_thumb = 1'b0;
                i_redirect_pc = '0;
                i_fill_addr = '0;
                i_fill_data = '0;
                i_pc_from_alu = '0;
                i_taken = '0;
                i_stall_from_decode = 1'b1;                     // Frozen during refill.
                repeat (3) @(negedge i_clk);
                i_reset = 1'b0;

                for (int w = 0; w < `FETCH_MEM_WORDS; w++)
                begin
                        i_fill_en   = 1'b1;
                        i_fill_addr = w * 4;
                        i_fill_data = $random(seed);
                        @(negedge i_clk);
                end
                idle_inputs();
                repeat (20) @(negedge i_clk);
                i_thumb = 1'b1;                                 // PC plus 4.
                repeat (10) @(negedge i_clk);
                i_thumb = 1'b0;
                end_test("1 sequential fetch");

                for (int s = 0; s < 4; s++)
                begin
                        case (s)
                                0:       i_data_stall         = 1'b1;
                                1:       i_stall_from_shifter = 1'b1;
                                2:       i_stall_from_issue   = 1'b1;
                                default: i_stall_from_decode  = 1'b1;
                        endcase
                        repeat (3) @(negedge i_clk);
                        idle_inputs();
                        repeat (2) @(negedge i_clk);
                end
                i_data_stall     = 1'b1;                        // Wins over the ALU clear.
                i_clear_from_alu = 1'b1;
                i_redirect_pc    = 32'h200;
                i_pc_from_alu    = 32'h58;
                i_taken          = m_bht[5'h16];
                repeat (3) @(negedge i_clk);
                idle_inputs();
                repeat (2) @(negedge i_clk);
                end_test("2 stall priority");

                clear_to(0, 32'h100);
                wait_valid(4);
                repeat (4) @(negedge i_clk);
                clear_to(1, 32'h180);
                wait_valid(4);
                repeat (4) @(negedge i_clk);
                clear_to(2, 32'h1c0);
                wait_valid(4);
                repeat (4) @(negedge i_clk);
                i_data_stall = 1'b1;                            // Writeback still wins.
                clear_to(0, 32'h20);
                wait_valid(4);
                repeat (4) @(negedge i_clk);
                end_test("3 clears with redirect");

                clear_to(2, 32'h3f8);                           // Runs into the end.
                repeat (10) @(negedge i_clk);
                clear_to(0, 32'h10);
                wait_valid(4);
                repeat (4) @(negedge i_clk);
                end_test("4 abort and sleep");

                bht_update(32'h40, 1'b1);
                bht_update(32'h40, 1'b1);
                bht_update(32'h40, 1'b0);
                bht_update(32'h44, 1'b1);
                bht_update(32'h48, 1'b1);
                bht_update(32'h48, 1'b1);
                bht_update(32'h48, 1'b1);
                bht_update(32'h4c, 1'b0);
                clear_to(0, 32'h40);
                wait_valid(4);
                // Counter of 0x40 must stay while the PC sits at 0x44.
                i_stall_from_issue = 1'b1;
                repeat (2) @(negedge i_clk);
                idle_inputs();
                repeat (10) @(negedge i_clk);                   // Past 0x58 too.
                end_test("5 branch history");

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

        initial
        begin
                repeat (WD_CYCLES) @(posedge i_clk);
                $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
                $display("CHECKS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
fetch_pkg.sv
fetch_ctrl.sv
pc_sequencer.sv
instr_mem.sv
branch_history.sv
fetch_buffer.sv
fetch_top.sv
tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.
# Exit status is 1 when the build or run breaks, or the log shows failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
        -f vlog.f -o sim_fetch > build.log 2>&1 \
        && ./obj_dir/sim_fetch > sim.log 2>&1 \
        || { cat build.log sim.log 2> /dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
